// File: verilog/ex_pkg.sv
package ex_pkg;

  parameter int HISTORY_BITS = 8;  // Branch history length

  typedef logic [63:0]             word_t;
  typedef logic [31:0]             inst_t;
  typedef logic [7:0]              tag_t;
  typedef logic [HISTORY_BITS-1:0] pht_idx_t;

  //////////////////////////////////////////////////////////////////////////////
  // Decoder selects
  //////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    opa_rega,
    opa_mem_disp,
    opa_npc,
    opa_not3
  } opa_sel_e;

  typedef enum logic [1:0] {
    opb_regb,
    opb_alu_imm,
    opb_br_disp
  } opb_sel_e;

  typedef enum logic [4:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_cmpeq,
    alu_cmpult,
    alu_mulq
  } alu_func_e;

  //////////////////////////////////////////////////////////////////////////////
  // Buses
  //////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic      valid;
    word_t     npc;        // PC+4
    word_t     ppc;        // Predicted next PC
    pht_idx_t  pht_idx;
    inst_t     ir;
    tag_t      dest_tag;
    word_t     rega;
    word_t     regb;
    opa_sel_e  opa_sel;
    opb_sel_e  opb_sel;
    alu_func_e alu_func;
    logic      cond_br;
    logic      uncond_br;
    logic      rd_mem;
    logic      wr_mem;
  } ex_issue_t;

  typedef struct packed {
    logic     valid;
    word_t    npc;
    tag_t     dest_tag;
    word_t    value;
    logic     is_branch;
    logic     taken;
    logic     mispredict;
    pht_idx_t pht_idx;
    word_t    cpc;         // Corrected PC
  } int_out_t;

  typedef struct packed {
    logic  valid;
    word_t npc;
    tag_t  dest_tag;
    word_t value;
  } mult_out_t;

  typedef struct packed {
    logic  valid;
    tag_t  tag;
    word_t value;
  } mem_ret_t;

  typedef struct packed {
    logic     valid;
    word_t    npc;
    tag_t     dest_tag;
    word_t    value;
    logic     mispredict;
    logic     taken;
    logic     is_branch;
    pht_idx_t pht_idx;
    word_t    cpc;
  } ex_result_t;

  typedef struct packed {
    logic  valid;
    tag_t  tag;
    word_t address;
    word_t value;          // Store data
  } lsq_req_t;

endpackage

// File: verilog/ex_int_unit.sv
`timescale 1ns/1ps

module ex_int_unit import ex_pkg::*; (
  input  ex_issue_t issue,
  input  logic      stall,
  output int_out_t  int_out,
  output logic      mult_req,
  output word_t     opa,
  output word_t     opb,
  output lsq_req_t  lsq_req
);

  // Branch conditions, instruction bits 28:26
  localparam logic [2:0] br_blbc = 3'b000;
  localparam logic [2:0] br_beq  = 3'b001;
  localparam logic [2:0] br_blt  = 3'b010;
  localparam logic [2:0] br_ble  = 3'b011;
  localparam logic [2:0] br_blbs = 3'b100;
  localparam logic [2:0] br_bne  = 3'b101;
  localparam logic [2:0] br_bge  = 3'b110;
  localparam logic [2:0] br_bgt  = 3'b111;

  word_t mem_disp;
  word_t br_disp;
  word_t alu_imm;
  word_t alu_res;
  logic  is_mulq;
  logic  is_mem;
  logic  is_branch;
  logic  cond;
  logic  taken;

  assign mem_disp = {{48{issue.ir[15]}}, issue.ir[15:0]};
  assign br_disp  = {{41{issue.ir[20]}}, issue.ir[20:0], 2'b00};
  assign alu_imm  = {56'b0, issue.ir[20:13]};

  //////////////////////////////////////////////////////////////////////////////
  // Operand muxes and ALU
  //////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (issue.opa_sel)
      opa_rega:     opa = issue.rega;
      opa_mem_disp: opa = mem_disp;
      opa_npc:      opa = issue.npc;
      default:      opa = ~64'h3;     // opa_not3
    endcase
    case (issue.opb_sel)
      opb_regb:     opb = issue.regb;
      opb_alu_imm:  opb = alu_imm;
      opb_br_disp:  opb = br_disp;
      default:      opb = '0;         // Unused encoding
    endcase
  end

  always_comb
  begin
    case (issue.alu_func)
      alu_add:    alu_res = opa + opb;
      alu_sub:    alu_res = opa - opb;
      alu_and:    alu_res = opa & opb;
      alu_or:     alu_res = opa | opb;
      alu_xor:    alu_res = opa ^ opb;
      alu_sll:    alu_res = opa << opb[5:0];
      alu_srl:    alu_res = opa >> opb[5:0];
      alu_sra:    alu_res = word_t'($signed(opa) >>> opb[5:0]);
      alu_cmpeq:  alu_res = {63'b0, opa == opb};
      alu_cmpult: alu_res = {63'b0, opa < opb};
      default:    alu_res = '0;       // mulq is handled by the multiplier
    endcase
  end

  //////////////////////////////////////////////////////////////////////////////
  // Branch resolution
  //////////////////////////////////////////////////////////////////////////////

  // Condition always tested on regA
  always_comb
  begin
    case (issue.ir[28:26])
      br_blbc: cond = ~issue.rega[0];
      br_beq:  cond = issue.rega == '0;
      br_blt:  cond = issue.rega[63];
      br_ble:  cond = issue.rega[63] | (issue.rega == '0);
      br_blbs: cond = issue.rega[0];
      br_bne:  cond = issue.rega != '0;
      br_bge:  cond = ~issue.rega[63];
      br_bgt:  cond = ~issue.rega[63] & (issue.rega != '0);
      default: cond = 1'b0;
    endcase
  end

  assign is_branch = issue.cond_br | issue.uncond_br;
  assign taken     = issue.uncond_br | (issue.cond_br & cond);
  assign is_mulq   = issue.alu_func == alu_mulq;
  assign is_mem    = issue.rd_mem | issue.wr_mem;

  always_comb
  begin
    int_out            = '0;
    int_out.valid      = issue.valid & ~is_mulq & ~is_mem;
    int_out.npc        = issue.npc;
    int_out.dest_tag   = issue.dest_tag;
    int_out.value      = is_branch ? issue.npc : alu_res;  // Link value for branches
    int_out.is_branch  = is_branch;
    int_out.taken      = taken;
    int_out.mispredict = is_branch & ((taken & (alu_res != issue.ppc)) |
                                      (~taken & (issue.ppc != issue.npc)));
    int_out.pht_idx    = issue.pht_idx;
    int_out.cpc        = taken ? alu_res : issue.npc;
  end

  // Only accepted instructions leave toward the multiplier or the LSQ
  assign mult_req = issue.valid & ~stall & is_mulq;

  assign lsq_req.valid   = issue.valid & ~stall & is_mem;
  assign lsq_req.tag     = issue.dest_tag;
  assign lsq_req.address = alu_res;
  assign lsq_req.value   = issue.rega;

endmodule

// File: verilog/ex_mult.sv
`timescale 1ns/1ps

module ex_mult import ex_pkg::*; #(
  parameter int MULT_STAGES = 4
) (
  input  logic      clock,
  input  logic      rst_n,
  input  logic      req,
  input  word_t     npc,
  input  tag_t      dest_tag,
  input  word_t     mplier,
  input  word_t     mcand,
  input  logic      freeze,
  output mult_out_t mult_out
);

  localparam int STEP = 64 / MULT_STAGES;  // Multiplier bits consumed per stage

  // Stage registers
  logic  valid_r  [MULT_STAGES];
  tag_t  tag_r    [MULT_STAGES];
  word_t npc_r    [MULT_STAGES];
  word_t prod_r   [MULT_STAGES];
  word_t mplier_r [MULT_STAGES];
  word_t mcand_r  [MULT_STAGES];

  // What each stage sees on its input side
  logic  in_valid  [MULT_STAGES];
  tag_t  in_tag    [MULT_STAGES];
  word_t in_npc    [MULT_STAGES];
  word_t in_prod   [MULT_STAGES];
  word_t in_mplier [MULT_STAGES];
  word_t in_mcand  [MULT_STAGES];

  always_comb
  begin
    in_valid[0]  = req;
    in_tag[0]    = dest_tag;
    in_npc[0]    = npc;
    in_prod[0]   = '0;
    in_mplier[0] = mplier;
    in_mcand[0]  = mcand;
    for (int k = 1; k < MULT_STAGES; k++)
    begin
      in_valid[k]  = valid_r[k-1];
      in_tag[k]    = tag_r[k-1];
      in_npc[k]    = npc_r[k-1];
      in_prod[k]   = prod_r[k-1];
      in_mplier[k] = mplier_r[k-1];
      in_mcand[k]  = mcand_r[k-1];
    end
  end

  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int k = 0; k < MULT_STAGES; k++)
        valid_r[k] <= 1'b0;
    end
    else if (!freeze)  // Whole pipe holds together
    begin
      for (int k = 0; k < MULT_STAGES; k++)
        valid_r[k] <= in_valid[k];
    end
  end

  always_ff @(posedge clock)
  begin
    if (!freeze)
    begin
      for (int k = 0; k < MULT_STAGES; k++)
      begin
        tag_r[k]    <= in_tag[k];
        npc_r[k]    <= in_npc[k];
        prod_r[k]   <= in_prod[k] + in_mcand[k] * in_mplier[k][STEP-1:0];
        mplier_r[k] <= in_mplier[k] >> STEP;
        mcand_r[k]  <= in_mcand[k] << STEP;
      end
    end
  end

  assign mult_out.valid    = valid_r[MULT_STAGES-1];
  assign mult_out.npc      = npc_r[MULT_STAGES-1];
  assign mult_out.dest_tag = tag_r[MULT_STAGES-1];
  assign mult_out.value    = prod_r[MULT_STAGES-1];  // Low 64 bits of product

endmodule

// File: verilog/ex_result_arbiter.sv
`timescale 1ns/1ps

module ex_result_arbiter import ex_pkg::*; (
  input  logic       clock,
  input  logic       rst_n,
  input  logic       issue_valid,
  input  int_out_t   int_out,
  input  mult_out_t  mult_out,
  input  mem_ret_t   mem_ret,
  output logic       stall,
  output logic       mult_freeze,
  output ex_result_t result
);

  ex_result_t nxt;        // Winner of this cycle
  ex_result_t res_q;      // Registered payload
  logic       res_valid_q;

  // Any higher-priority source holds off issue
  assign stall       = issue_valid & (mem_ret.valid | mult_out.valid);
  assign mult_freeze = mem_ret.valid & mult_out.valid;  // Product cannot leave

  //////////////////////////////////////////////////////////////////////////////
  // Fixed priority: memory, multiplier, integer unit
  //////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    nxt = '0;
    if (mem_ret.valid)
    begin
      nxt.valid    = 1'b1;
      nxt.dest_tag = mem_ret.tag;
      nxt.value    = mem_ret.value;
    end
    else if (mult_out.valid)
    begin
      nxt.valid    = 1'b1;
      nxt.npc      = mult_out.npc;
      nxt.dest_tag = mult_out.dest_tag;
      nxt.value    = mult_out.value;
    end
    else if (int_out.valid)
    begin
      // stall is low here, so the instruction is accepted this cycle
      nxt.valid      = 1'b1;
      nxt.npc        = int_out.npc;
      nxt.dest_tag   = int_out.dest_tag;
      nxt.value      = int_out.value;
      nxt.mispredict = int_out.mispredict;
      nxt.taken      = int_out.taken;
      nxt.is_branch  = int_out.is_branch;
      nxt.pht_idx    = int_out.pht_idx;
      nxt.cpc        = int_out.cpc;
    end
  end

  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
      res_valid_q <= 1'b0;
    else
      res_valid_q <= nxt.valid;
  end

  always_ff @(posedge clock)
  begin
    res_q <= nxt;
  end

  always_comb
  begin
    result       = res_q;
    result.valid = res_valid_q;
  end

endmodule

// File: verilog/ex_stage.sv
`timescale 1ns/1ps

module ex_stage import ex_pkg::*; #(
  parameter int MULT_STAGES = 4
) (
  input  logic       clock,
  input  logic       rst_n,
  input  ex_issue_t  issue,
  input  mem_ret_t   mem_ret,
  output logic       stall,
  output ex_result_t result,
  output lsq_req_t   lsq_req
);

  int_out_t  int_out;
  mult_out_t mult_out;
  logic      mult_req;
  logic      mult_freeze;
  word_t     opa;          // Also the multiplier operands
  word_t     opb;

  //////////////////////////////////////////////////////////////////////////////
  // Integer unit, multiplier, result bus
  //////////////////////////////////////////////////////////////////////////////

  ex_int_unit u_int_unit (
    .issue    (issue),
    .stall    (stall),
    .int_out  (int_out),
    .mult_req (mult_req),
    .opa      (opa),
    .opb      (opb),
    .lsq_req  (lsq_req)
  );

  ex_mult #(
    .MULT_STAGES (MULT_STAGES)
  ) u_mult (
    .clock    (clock),
    .rst_n    (rst_n),
    .req      (mult_req),
    .npc      (issue.npc),
    .dest_tag (issue.dest_tag),
    .mplier   (opa),
    .mcand    (opb),
    .freeze   (mult_freeze),
    .mult_out (mult_out)
  );

  ex_result_arbiter u_arbiter (
    .clock       (clock),
    .rst_n       (rst_n),
    .issue_valid (issue.valid),
    .int_out     (int_out),
    .mult_out    (mult_out),
    .mem_ret     (mem_ret),
    .stall       (stall),
    .mult_freeze (mult_freeze),
    .result      (result)
  );

endmodule

// File: test/ex_clock_gen.sv
`timescale 1ns/1ps

module ex_clock_gen #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 10
) (
  output logic clock,
  output logic rst_n
);

  initial
  begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  // Release on a falling edge, away from the flops
  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    rst_n = 1'b1;
  end

endmodule

// File: test/ex_stage_sva.sv
`timescale 1ns/1ps

module ex_stage_sva import ex_pkg::*; (
  input logic       clock,
  input logic       rst_n,
  input ex_issue_t  issue,
  input mem_ret_t   mem_ret,
  input mult_out_t  mult_out,
  input logic       mult_freeze,
  input logic       stall,
  input ex_result_t result
);

  // Issue waits only while a higher-priority source owns the bus
  stall_bus: assert property (@(posedge clock) disable iff (!rst_n)
    stall |=> result.valid)
    else $error("stall raised while no other source took the result bus");

  accepted_int: assert property (@(posedge clock) disable iff (!rst_n)
    issue.valid && !stall && issue.alu_func != alu_mulq && !issue.rd_mem && !issue.wr_mem
    |=> result.valid && result.dest_tag == $past(issue.dest_tag))
    else $error("accepted integer instruction missing from the result bus");

  product_leaves: assert property (@(posedge clock) disable iff (!rst_n)
    mult_out.valid && !mem_ret.valid |=> result.valid &&
      result.dest_tag == $past(mult_out.dest_tag) && result.value == $past(mult_out.value))
    else $error("product did not reach the result bus while memory was idle");

  mem_first: assert property (@(posedge clock) disable iff (!rst_n)
    mem_ret.valid |=> result.valid && result.dest_tag == $past(mem_ret.tag) &&
                      result.value == $past(mem_ret.value))
    else $error("memory return did not reach the result bus one cycle later");

  frozen_hold: assert property (@(posedge clock) disable iff (!rst_n)
    mult_freeze |=> mult_out.valid && $stable(mult_out.value) && $stable(mult_out.dest_tag))
    else $error("frozen product changed or was lost");

  reset_clear: assert property (@(posedge clock)
    !rst_n |-> !result.valid && !mult_out.valid)
    else $error("valid bits set during reset");

endmodule

bind ex_stage ex_stage_sva u_sva (
  .clock       (clock),
  .rst_n       (rst_n),
  .issue       (issue),
  .mem_ret     (mem_ret),
  .mult_out    (mult_out),
  .mult_freeze (mult_freeze),
  .stall       (stall),
  .result      (result)
);

// File: test/ex_stage_tb.sv
`timescale 1ns/1ps

module ex_stage_tb import ex_pkg::*; ();

  localparam int MULT_STAGES = 4;
  localparam int TIMEOUT     = 50;   // Cycles allowed for any wait

  logic       clock;
  logic       rst_n;
  ex_issue_t  issue;
  mem_ret_t   mem_ret;
  logic       stall;
  ex_result_t result;
  lsq_req_t   lsq_req;

  lsq_req_t   lsq_seen;              // Sampled at acceptance
  integer     seed;
  int         checks;
  int         errors;
  int         tests;
  string      test_name;             // Test now running

  ex_clock_gen #(
    .PERIOD       (40),
    .RESET_CYCLES (10)
  ) u_clock_gen (
    .clock (clock),
    .rst_n (rst_n)
  );

  ex_stage #(
    .MULT_STAGES (MULT_STAGES)
  ) i_dut (
    .clock   (clock),
    .rst_n   (rst_n),
    .issue   (issue),
    .mem_ret (mem_ret),
    .stall   (stall),
    .result  (result),
    .lsq_req (lsq_req)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic word_t sign_extend(word_t v, int bits);
    return word_t'($signed(v << (64 - bits)) >>> (64 - bits));
  endfunction

  function automatic word_t operand_a(ex_issue_t op);
    case (op.opa_sel)
      opa_rega:     return op.rega;
      opa_mem_disp: return sign_extend(word_t'(op.ir[15:0]), 16);
      opa_npc:      return op.npc;
      default:      return ~word_t'(3);
    endcase
  endfunction

  function automatic word_t operand_b(ex_issue_t op);
    case (op.opb_sel)
      opb_regb:    return op.regb;
      opb_alu_imm: return word_t'(op.ir[20:13]);
      opb_br_disp: return sign_extend(word_t'(op.ir[20:0]), 21) << 2;
      default:     return '0;
    endcase
  endfunction

  function automatic word_t alu_model(alu_func_e func, word_t a, word_t b);
    case (func)
      alu_add:    return a + b;
      alu_sub:    return a - b;
      alu_and:    return a & b;
      alu_or:     return a | b;
      alu_xor:    return a ^ b;
      alu_sll:    return a << b[5:0];
      alu_srl:    return a >> b[5:0];
      alu_sra:    return word_t'($signed(a) >>> b[5:0]);
      alu_cmpeq:  return word_t'(a == b);
      alu_cmpult: return word_t'(a < b);
      alu_mulq:   return a * b;    // Low 64 bits
      default:    return '0;
    endcase
  endfunction

  function automatic logic cond_holds(logic [2:0] code, word_t a);
    case (code)
      3'b000:  return !a[0];              // blbc
      3'b001:  return a == 0;             // beq
      3'b010:  return $signed(a) < 0;     // blt
      3'b011:  return $signed(a) <= 0;    // ble
      3'b100:  return a[0];               // blbs
      3'b101:  return a != 0;             // bne
      3'b110:  return $signed(a) >= 0;    // bge
      default: return $signed(a) > 0;     // bgt
    endcase
  endfunction

  function automatic ex_issue_t make_op(alu_func_e func, opa_sel_e opa_sel, opb_sel_e opb_sel,
                                        inst_t ir, word_t rega, word_t regb, tag_t tag);
    ex_issue_t op;
    op          = '0;
    op.valid    = 1'b1;
    op.npc      = 64'h0000_0000_0040_1004;
    op.ppc      = op.npc;
    op.ir       = ir;
    op.dest_tag = tag;
    op.rega     = rega;
    op.regb     = regb;
    op.opa_sel  = opa_sel;
    op.opb_sel  = opb_sel;
    op.alu_func = func;
    return op;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Drive and check helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("error: %s %s expected %h actual %h", test_name, name, exp, act);
    end
  endtask

  task automatic report(input string name, input int start);
    tests++;
    if (errors == start)
      $display("%-14s ok", name);
    else
      $display("%-14s FAILED with %0d errors", name, errors - start);
  endtask

  // Returns at the rising edge that accepts the instruction
  task automatic send(input ex_issue_t op, input string name);
    int waited;
    waited = 0;
    @(negedge clock);
    issue = op;
    @(posedge clock);
    while (stall && waited < TIMEOUT)
    begin
      waited++;
      @(posedge clock);
    end
    if (stall)
    begin
      errors++;
      $display("%s was still stalled after %0d cycles", name, TIMEOUT);
    end
    lsq_seen = lsq_req;
  endtask

  task automatic wait_result(input string name, output int cycles);
    cycles = 0;
    do
    begin
      @(negedge clock);
      issue.valid = 1'b0;
      cycles++;
    end
    while (!result.valid && cycles < TIMEOUT);
    if (!result.valid)
    begin
      errors++;
      $display("%s produced no result within %0d cycles", name, TIMEOUT);
    end
  endtask

  task automatic expect_quiet(input string name, input int cycles);
    int n;
    for (n = 0; n < cycles; n++)
    begin
      @(negedge clock);
      issue.valid = 1'b0;
      compare({name, " no result"}, 0, result.valid);
    end
  endtask

  task automatic alu_case(input string name, input ex_issue_t op, input int latency);
    int    cycles;
    word_t exp;
    exp = alu_model(op.alu_func, operand_a(op), operand_b(op));
    send(op, name);
    wait_result(name, cycles);
    compare({name, " latency"}, latency, cycles);
    compare({name, " value"}, exp, result.value);
    compare({name, " tag"}, op.dest_tag, result.dest_tag);
    compare({name, " npc"}, op.npc, result.npc);
  endtask

  task automatic branch_case(input string name, input logic [2:0] code, input logic uncond,
                             input word_t rega, input logic [20:0] disp, input logic good_ppc);
    int        cycles;
    ex_issue_t op;
    word_t     target;
    logic      taken;
    logic      mispredict;
    string     full;
    op           = make_op(alu_add, opa_npc, opb_br_disp, {3'b000, code, 5'b00000, disp},
                           rega, '0, 8'h30);
    op.cond_br   = ~uncond;
    op.uncond_br = uncond;
    op.pht_idx   = pht_idx_t'({code, uncond, good_ppc, 3'b101});
    target       = op.npc + (sign_extend(word_t'(disp), 21) << 2);
    taken        = uncond | cond_holds(code, rega);
    if (taken)
      op.ppc = good_ppc ? target : op.npc;
    else
      op.ppc = good_ppc ? op.npc : target;
    mispredict = taken ? (op.ppc != target) : (op.ppc != op.npc);
    full       = $sformatf("%s %s", name, good_ppc ? "good ppc" : "bad ppc");
    send(op, full);
    wait_result(full, cycles);
    compare({full, " latency"}, 1, cycles);
    compare({full, " is_branch"}, 1, result.is_branch);
    compare({full, " taken"}, taken, result.taken);
    compare({full, " mispredict"}, mispredict, result.mispredict);
    compare({full, " cpc"}, taken ? target : op.npc, result.cpc);
    compare({full, " link"}, op.npc, result.value);
    compare({full, " pht_idx"}, op.pht_idx, result.pht_idx);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic alu_ops();
    int        start;
    int        i;
    integer    r;
    ex_issue_t op;
    start     = errors;
    test_name = "alu_ops";
    alu_case("add", make_op(alu_add, opa_rega, opb_regb, '0,
             64'h1234_5678_9abc_def0, 64'h0fed_cba9_8765_4321, 8'h01), 1);
    alu_case("sub", make_op(alu_sub, opa_rega, opb_regb, '0, 64'd5, 64'd9, 8'h02), 1);
    alu_case("and imm", make_op(alu_and, opa_rega, opb_alu_imm, {11'b0, 8'ha5, 13'b0},
             64'hffff_0000_ffff_00ff, '0, 8'h03), 1);
    alu_case("or not3", make_op(alu_or, opa_not3, opb_alu_imm, {11'b0, 8'h02, 13'b0},
             '0, '0, 8'h04), 1);
    alu_case("xor", make_op(alu_xor, opa_rega, opb_regb, '0,
             64'haaaa_5555_aaaa_5555, 64'h0ff0_0ff0_0ff0_0ff0, 8'h05), 1);
    alu_case("sll imm", make_op(alu_sll, opa_rega, opb_alu_imm, {11'b0, 8'h24, 13'b0},
             64'h0000_0000_0000_0c03, '0, 8'h06), 1);
    alu_case("srl", make_op(alu_srl, opa_rega, opb_regb, '0, 64'h8000_0000_0000_0000, 64'd63,
             8'h07), 1);
    alu_case("sra", make_op(alu_sra, opa_rega, opb_regb, '0, 64'hf000_0000_0000_1230, 64'd4,
             8'h08), 1);
    alu_case("cmpeq", make_op(alu_cmpeq, opa_rega, opb_regb, '0, 64'h77, 64'h77, 8'h09), 1);
    alu_case("cmpult", make_op(alu_cmpult, opa_rega, opb_regb, '0, 64'h1, 64'hffff_ffff_ffff_fff0,
             8'h0a), 1);
    alu_case("add disp", make_op(alu_add, opa_mem_disp, opb_regb, 32'h0000_8000, '0,
             64'h0000_0000_0010_0000, 8'h0b), 1);
    for (i = 0; i < 20; i++)
    begin
      r  = $random(seed);
      op = make_op(alu_func_e'(5'($unsigned(r) % 10)),
                   r[5] ? opa_rega : opa_not3,
                   r[6] ? opb_regb : opb_alu_imm,
                   $random(seed), {$random(seed), $random(seed)},
                   {$random(seed), $random(seed)}, tag_t'(8'h80 + i));
      alu_case($sformatf("random %0d", i), op, 1);
    end
    report("alu_ops", start);
  endtask

  task automatic mult_latency();
    int        start;
    int        cycles;
    int        i;
    ex_issue_t burst [4];
    start     = errors;
    test_name = "mult_latency";
    alu_case("mulq", make_op(alu_mulq, opa_rega, opb_regb, '0,
             64'hdead_beef_1234_5678, 64'h0000_0012_3456_789a, 8'h42), MULT_STAGES + 1);
    for (i = 0; i < 4; i++)
    begin
      burst[i] = make_op(alu_mulq, opa_rega, opb_regb, '0,
                         {$random(seed), $random(seed)}, {$random(seed), $random(seed)},
                         tag_t'(8'h50 + i));
      burst[i].npc = burst[i].npc + word_t'(4 * i);
      send(burst[i], "mulq burst");
    end
    // First product is counted from the last acceptance
    for (i = 0; i < 4; i++)
    begin
      if (i == 0)
      begin
        wait_result("mulq burst", cycles);
        compare("mulq burst latency", MULT_STAGES - 2, cycles);
      end
      else
        @(negedge clock);
      compare("mulq burst valid", 1, result.valid);
      compare("mulq burst tag", burst[i].dest_tag, result.dest_tag);
      compare("mulq burst npc", burst[i].npc, result.npc);
      compare("mulq burst value", alu_model(alu_mulq, burst[i].rega, burst[i].regb),
              result.value);
    end
    report("mult_latency", start);
  endtask

  task automatic branches();
    int start;
    int g;
    start     = errors;
    test_name = "branches";
    for (g = 0; g < 2; g++)
    begin
      branch_case("beq taken", 3'b001, 1'b0, 64'h0, 21'h000010, g == 1);
      branch_case("bne not taken", 3'b101, 1'b0, 64'h0, 21'h000020, g == 1);
      branch_case("blt backward", 3'b010, 1'b0, 64'hffff_ffff_ffff_fff0, 21'h1ffff8, g == 1);
      branch_case("bgt not taken", 3'b111, 1'b0, 64'h0, 21'h000040, g == 1);
      branch_case("br", 3'b000, 1'b1, 64'h1, 21'h000100, g == 1);
    end
    report("branches", start);
  endtask

  task automatic mem_ops();
    int        start;
    ex_issue_t op;
    start     = errors;
    test_name = "mem_ops";
    // Base address travels in regb
    op        = make_op(alu_add, opa_mem_disp, opb_regb, 32'h0000_fff0,
                        64'h0, 64'h0000_0000_0001_0000, 8'h21);
    op.rd_mem = 1'b1;
    send(op, "load");
    compare("load lsq valid", 1, lsq_seen.valid);
    compare("load lsq address", sign_extend(64'hfff0, 16) + op.regb, lsq_seen.address);
    compare("load lsq tag", op.dest_tag, lsq_seen.tag);
    expect_quiet("load", 2);
    op        = make_op(alu_add, opa_mem_disp, opb_regb, 32'h0000_0123,
                        64'hcafe_f00d_0000_1234, 64'h0000_0000_0002_0000, 8'h22);
    op.wr_mem = 1'b1;
    send(op, "store");
    compare("store lsq valid", 1, lsq_seen.valid);
    compare("store lsq address", 64'h123 + op.regb, lsq_seen.address);
    compare("store lsq data", op.rega, lsq_seen.value);
    compare("store lsq tag", op.dest_tag, lsq_seen.tag);
    expect_quiet("store", MULT_STAGES);
    report("mem_ops", start);
  endtask

  task automatic arbitration();
    int        start;
    int        n;
    ex_issue_t op;
    word_t     exp;
    start     = errors;
    test_name = "arbitration";
    op  = make_op(alu_xor, opa_rega, opb_regb, '0,
                  64'h5555_0000_ffff_1111, 64'h0f0f_0f0f_0f0f_0f0f, 8'h61);
    exp = alu_model(op.alu_func, operand_a(op), operand_b(op));
    @(negedge clock);
    issue         = op;
    mem_ret.valid = 1'b1;
    mem_ret.tag   = 8'h62;
    mem_ret.value = 64'h0123_4567_89ab_cdef;
    @(posedge clock);
    compare("held stall", 1, stall);
    @(negedge clock);
    mem_ret.valid = 1'b0;
    compare("held mem valid", 1, result.valid);
    compare("held mem tag", 8'h62, result.dest_tag);
    compare("held mem value", 64'h0123_4567_89ab_cdef, result.value);
    @(posedge clock);
    compare("held stall released", 0, stall);
    @(negedge clock);
    issue.valid = 1'b0;
    compare("held int valid", 1, result.valid);
    compare("held int tag", op.dest_tag, result.dest_tag);
    compare("held int value", exp, result.value);

    // Memory return lands on the cycle the product is ready
    op            = make_op(alu_mulq, opa_rega, opb_regb, '0,
                            64'h0000_0001_0000_0003, 64'h0000_0000_7fff_0005, 8'h63);
    exp           = alu_model(alu_mulq, op.rega, op.regb);
    mem_ret.tag   = 8'h64;
    mem_ret.value = 64'hfeed_0000_beef_0000;
    send(op, "collide");
    for (n = 1; n <= MULT_STAGES + 2; n++)
    begin
      @(negedge clock);
      issue.valid   = 1'b0;
      mem_ret.valid = (n == MULT_STAGES);
      if (n == MULT_STAGES + 1)
      begin
        compare("collide mem valid", 1, result.valid);
        compare("collide mem tag", 8'h64, result.dest_tag);
        compare("collide mem value", 64'hfeed_0000_beef_0000, result.value);
      end
      if (n == MULT_STAGES + 2)
      begin
        compare("collide product valid", 1, result.valid);
        compare("collide product tag", op.dest_tag, result.dest_tag);
        compare("collide product value", exp, result.value);
      end
    end
    report("arbitration", start);
  endtask

  initial
  begin
    int waited;
    seed      = 32'h83e97c7f;
    issue     = '0;
    mem_ret   = '0;
    checks    = 0;
    errors    = 0;
    tests     = 0;
    test_name = "reset";
    waited    = 0;
    while (rst_n !== 1'b1 && waited < TIMEOUT)
    begin
      waited++;
      @(negedge clock);
    end
    if (rst_n !== 1'b1)
    begin
      errors++;
      $display("reset was never released");
    end
    alu_ops();
    mult_latency();
    branches();
    mem_ops();
    arbitration();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// File: ex_stage.f
verilog/ex_pkg.sv
verilog/ex_int_unit.sv
verilog/ex_mult.sv
verilog/ex_result_arbiter.sv
verilog/ex_stage.sv
test/ex_clock_gen.sv
test/ex_stage_sva.sv
test/ex_stage_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = ex_stage_tb
FILELIST = ex_stage.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "Test FAILED"; exit 1; fi
	@if ! grep -q "Simulation passed" $(LOG); then echo "Test FAILED, run incomplete"; exit 1; fi
	@echo "Test PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
